//--- source/stream_fmt_pkg.sv
package stream_fmt_pkg;

    // converter side, one word per clock
    localparam int s_data_width = 128;

    // DMA side beat
    localparam int m_data_width = 64;

    // number of DMA beats per converter word
    localparam int beats_per_word = s_data_width / m_data_width;

    // lane layout inside a converter word
    localparam int lane_width = 16;
    localparam int lane_count = s_data_width / lane_width;

    // ADC resolution, sample sits in the low bits of a lane
    localparam int adc_width = 12;

    // selects the low or high half of a word during the drain
    localparam int beat_sel_width = $clog2(beats_per_word);

endpackage

//--- source/capture_cfg_pkg.sv
package capture_cfg_pkg;

    // trigger level in percent of full scale
    localparam int threshold_pct = 10;
    localparam int threshold_level =
        ((2 ** stream_fmt_pkg::adc_width) * threshold_pct) / 100;

    // window around the trigger word, trigger word counts as post
    localparam int pre_len = 4;
    localparam int post_len = 12;
    localparam int acqui_len = pre_len + post_len;
    localparam int addr_width = $clog2(acqui_len);

    // DMA beats in one frame
    localparam int frame_beats = acqui_len * stream_fmt_pkg::beats_per_word;

    localparam int timestamp_width = 16;

    // detector arming
    typedef enum logic [1:0] {arm_idle, arm_wait_low, arm_armed} arm_state_t;

    // ring buffer phases
    typedef enum logic [1:0] {buf_fill, buf_post, buf_drain} buf_state_t;

endpackage

//--- source/threshold_trigger.sv
`timescale 1ns/1ps

module threshold_trigger
(
    input  logic                                        AXIS_ACLK,
    input  logic                                        AXIS_ARESETN,
    input  logic                                        s_axis_tvalid,
    input  logic [stream_fmt_pkg::s_data_width-1:0]     s_axis_tdata,
    input  logic                                        frame_done,
    output logic                                        trig_pulse,
    output logic [capture_cfg_pkg::timestamp_width-1:0] trig_stamp
);

    import stream_fmt_pkg::*;
    import capture_cfg_pkg::*;

    arm_state_t arm_state;
    logic over_level;
    logic fire;
    logic [timestamp_width-1:0] word_cnt;

    // any lane above the level
    always_comb
    begin
        over_level = 1'b0;
        for (int i = 0; i < lane_count; i++)
        begin
            if (s_axis_tdata[i*lane_width +: adc_width] > adc_width'(threshold_level))
            begin
                over_level = 1'b1;
            end
        end
    end

    assign fire = (arm_state == arm_armed) && s_axis_tvalid && over_level;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            arm_state  <= arm_wait_low;
            trig_pulse <= 1'b0;
            word_cnt   <= '0;
        end
        else
        begin
            trig_pulse <= fire;
            // wraps at the stamp width
            if (s_axis_tvalid)
                word_cnt <= word_cnt + 1'b1;
            case (arm_state)
                arm_idle:
                    if (frame_done)
                        arm_state <= arm_wait_low;
                // need one quiet word before arming
                arm_wait_low:
                    if (s_axis_tvalid && !over_level)
                        arm_state <= arm_armed;
                arm_armed:
                    if (fire)
                        arm_state <= arm_idle;
                default:
                    arm_state <= arm_wait_low;
            endcase
        end
    end

    // count of words before the trigger word
    always_ff @(posedge AXIS_ACLK)
    begin
        if (fire)
            trig_stamp <= word_cnt;
    end

endmodule

//--- source/m_axis_if.sv
`timescale 1ns/1ps

module m_axis_if
(
    input  logic                                        AXIS_ACLK,
    input  logic                                        AXIS_ARESETN,
    input  logic                                        s_axis_tvalid,
    input  logic [stream_fmt_pkg::s_data_width-1:0]     s_axis_tdata,
    input  logic                                        trig_pulse,
    input  logic [capture_cfg_pkg::timestamp_width-1:0] trig_stamp,
    input  logic [stream_fmt_pkg::m_data_width-1:0]     rd_data,
    input  logic                                        rd_valid,
    input  logic                                        first_beat,
    input  logic                                        last_beat,
    input  logic                                        m_axis_tready,
    output logic                                        wr_en,
    output logic [stream_fmt_pkg::s_data_width-1:0]     wr_data,
    output logic                                        wr_trig,
    output logic                                        rd_ack,
    output logic [stream_fmt_pkg::m_data_width-1:0]     m_axis_tdata,
    output logic                                        m_axis_tvalid,
    output logic                                        m_axis_tuser,
    output logic                                        m_axis_tlast
);

    import stream_fmt_pkg::*;
    import capture_cfg_pkg::*;

    logic [s_data_width-1:0] word_d;
    logic valid_d;
    logic [s_data_width-1:0] stamp_word;

    // one word delay so the trigger word meets trig_pulse
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            valid_d <= 1'b0;
        else
            valid_d <= s_axis_tvalid;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (s_axis_tvalid)
            word_d <= s_axis_tdata;
    end

    // timestamp replaces the trigger word, zero extended
    assign stamp_word = {{(s_data_width - timestamp_width){1'b0}}, trig_stamp};

    assign wr_en   = valid_d;
    assign wr_trig = valid_d && trig_pulse;
    assign wr_data = trig_pulse ? stamp_word : word_d;

    // buffer holds the beat steady until it is taken
    assign rd_ack = rd_valid && m_axis_tready;

    assign m_axis_tdata  = rd_data;
    assign m_axis_tvalid = rd_valid;

    // frame markers only on their own beat
    assign m_axis_tuser = rd_valid && first_beat;
    assign m_axis_tlast = rd_valid && last_beat;

endmodule

//--- source/ring_buffer.sv
`timescale 1ns/1ps

module ring_buffer
(
    input  logic                                    AXIS_ACLK,
    input  logic                                    AXIS_ARESETN,
    input  logic                                    wr_en,
    input  logic [stream_fmt_pkg::s_data_width-1:0] wr_data,
    input  logic                                    wr_trig,
    input  logic                                    rd_ack,
    output logic [stream_fmt_pkg::m_data_width-1:0] rd_data,
    output logic                                    rd_valid,
    output logic                                    first_beat,
    output logic                                    last_beat,
    output logic                                    capture_full,
    output logic                                    frame_done
);

    import stream_fmt_pkg::*;
    import capture_cfg_pkg::*;

    logic [s_data_width-1:0] mem [acqui_len];

    buf_state_t buf_state;
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] start_addr;
    logic [addr_width-1:0] post_cnt;
    logic [addr_width-1:0] rd_addr;
    logic [beat_sel_width-1:0] beat_sel;
    logic [addr_width+beat_sel_width-1:0] beat_cnt;
    logic [s_data_width-1:0] rd_word;
    logic wr_ok;
    logic trig_hit;

    // writes stop while a frame drains
    assign wr_ok    = wr_en && (buf_state != buf_drain);
    assign trig_hit = wr_ok && wr_trig && (buf_state == buf_fill);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (wr_ok)
            mem[wr_addr] <= wr_data;
    end

    // window starts pre_len words before the trigger word
    always_ff @(posedge AXIS_ACLK)
    begin
        if (trig_hit)
            start_addr <= wr_addr - addr_width'(pre_len);
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            buf_state  <= buf_fill;
            wr_addr    <= '0;
            post_cnt   <= '0;
            rd_addr    <= '0;
            beat_sel   <= '0;
            beat_cnt   <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (wr_ok)
                wr_addr <= wr_addr + 1'b1;
            case (buf_state)
                buf_fill:
                    if (trig_hit)
                    begin
                        // trigger word is the first post write
                        post_cnt  <= addr_width'(1);
                        buf_state <= buf_post;
                    end
                buf_post:
                    if (wr_ok)
                    begin
                        if (post_cnt == addr_width'(post_len - 1))
                        begin
                            buf_state <= buf_drain;
                            rd_addr   <= start_addr;
                            beat_sel  <= '0;
                            beat_cnt  <= '0;
                        end
                        else
                        begin
                            post_cnt <= post_cnt + 1'b1;
                        end
                    end
                buf_drain:
                    if (rd_ack)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        beat_sel <= beat_sel + 1'b1;
                        // next word after the high half
                        if (beat_sel == beat_sel_width'(beats_per_word - 1))
                            rd_addr <= rd_addr + 1'b1;
                        if (last_beat)
                        begin
                            buf_state  <= buf_fill;
                            frame_done <= 1'b1;
                        end
                    end
                default:
                    buf_state <= buf_fill;
            endcase
        end
    end

    // low half goes out first
    assign rd_word = mem[rd_addr];
    assign rd_data = rd_word[beat_sel*m_data_width +: m_data_width];

    assign rd_valid     = (buf_state == buf_drain);
    assign capture_full = (buf_state == buf_drain);
    assign first_beat   = (beat_cnt == '0);
    assign last_beat    = (beat_cnt == (addr_width + beat_sel_width)'(frame_beats - 1));

endmodule

//--- source/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top
(
    input  logic                                    AXIS_ACLK,
    input  logic                                    AXIS_ARESETN,
    input  logic                                    s_axis_tvalid,
    input  logic [stream_fmt_pkg::s_data_width-1:0] s_axis_tdata,
    output logic [stream_fmt_pkg::m_data_width-1:0] m_axis_tdata,
    output logic                                    m_axis_tvalid,
    output logic                                    m_axis_tuser,
    output logic                                    m_axis_tlast,
    input  logic                                    m_axis_tready,
    output logic                                    capture_full
);

    import stream_fmt_pkg::*;
    import capture_cfg_pkg::*;

    logic trig_pulse;
    logic [timestamp_width-1:0] trig_stamp;
    logic wr_en;
    logic [s_data_width-1:0] wr_data;
    logic wr_trig;
    logic rd_ack;
    logic [m_data_width-1:0] rd_data;
    logic rd_valid;
    logic first_beat;
    logic last_beat;
    logic frame_done;

    threshold_trigger i_trigger
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .frame_done    (frame_done),
        .trig_pulse    (trig_pulse),
        .trig_stamp    (trig_stamp)
    );

    // stream side, write path in and AXI-stream out
    m_axis_if i_stream_if
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .trig_pulse    (trig_pulse),
        .trig_stamp    (trig_stamp),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .first_beat    (first_beat),
        .last_beat     (last_beat),
        .m_axis_tready (m_axis_tready),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .wr_trig       (wr_trig),
        .rd_ack        (rd_ack),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast)
    );

    ring_buffer i_ring
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .wr_trig       (wr_trig),
        .rd_ack        (rd_ack),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .first_beat    (first_beat),
        .last_beat     (last_beat),
        .capture_full  (capture_full),
        .frame_done    (frame_done)
    );

endmodule

//--- test/tb_adc_capture.sv
`timescale 1ns/1ps

module tb_adc_capture;

    import stream_fmt_pkg::*;
    import capture_cfg_pkg::*;

    // six frames of fill and stalled drain doubled plus margin
    localparam int timeout_cycles = 6 * (acqui_len + 2 * frame_beats) * 2 + 200;

    logic AXIS_ACLK;
    logic AXIS_ARESETN;
    logic s_axis_tvalid;
    logic [s_data_width-1:0] s_axis_tdata;
    logic [m_data_width-1:0] m_axis_tdata;
    logic m_axis_tvalid;
    logic m_axis_tuser;
    logic m_axis_tlast;
    logic m_axis_tready;
    logic capture_full;

    int seed;
    int rnd;
    int cycle_count;
    int errors;
    int mark;
    int tests_passed;
    int tests_failed;
    logic stream_on;
    logic send_trig;
    logic trig_expect;
    logic ready_random;
    logic [s_data_width-1:0] next_word;
    logic [s_data_width-1:0] word_log [2048];
    int word_idx;
    int exp_trig [$];
    int beat_idx;
    int beats_taken;
    int frames_seen;
    int tuser_count;
    int tlast_count;
    int stall_count;
    int reset_edges;
    logic held;
    logic [m_data_width-1:0] held_data;
    logic held_user;
    logic held_last;

    adc_capture_top i_dut
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready),
        .capture_full  (capture_full)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #50 AXIS_ACLK = ~AXIS_ACLK;
    end

    task automatic report_mismatch(string name, logic [m_data_width-1:0] exp,
                                   logic [m_data_width-1:0] got);
        $display("[ERROR] %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    task automatic report_failure(string what);
        $display("error: %s", what);
        errors++;
    endtask

    // every lane at or below the threshold
    function automatic logic [s_data_width-1:0] quiet_word();
        logic [s_data_width-1:0] w;
        w = '0;
        for (int i = 0; i < lane_count; i++)
        begin
            w[i*lane_width +: lane_width] =
                lane_width'($unsigned($random(seed)) % (threshold_level + 1));
        end
        return w;
    endfunction

    // one random lane at full scale
    function automatic logic [s_data_width-1:0] trigger_word();
        logic [s_data_width-1:0] w;
        int lane;
        w = quiet_word();
        lane = $unsigned($random(seed)) % lane_count;
        w[lane*lane_width +: lane_width] = lane_width'((2 ** adc_width) - 1);
        return w;
    endfunction

    // window n-4 .. n+11 with the trigger word swapped for its index
    function automatic logic [m_data_width-1:0] expected_beat(int n, int b);
        logic [s_data_width-1:0] word;
        int w;
        w = n - pre_len + b / beats_per_word;
        word = '0;
        if (w == n)
            word[timestamp_width-1:0] = n[timestamp_width-1:0];
        else
            word = word_log[w];
        return word[(b % beats_per_word) * m_data_width +: m_data_width];
    endfunction

    task automatic check_beat();
        logic [m_data_width-1:0] exp_data;
        if (exp_trig.size() == 0)
        begin
            report_failure("a beat was taken while no frame was expected");
        end
        else
        begin
            exp_data = expected_beat(exp_trig[0], beat_idx);
            assert (m_axis_tdata === exp_data)
                else report_mismatch($sformatf("m_axis_tdata beat %0d", beat_idx),
                                     exp_data, m_axis_tdata);
            assert (m_axis_tuser === (beat_idx == 0))
                else report_mismatch("m_axis_tuser", beat_idx == 0, m_axis_tuser);
            assert (m_axis_tlast === (beat_idx == frame_beats - 1))
                else report_mismatch("m_axis_tlast", beat_idx == frame_beats - 1, m_axis_tlast);
            if (m_axis_tuser)
                tuser_count++;
            if (m_axis_tlast)
                tlast_count++;
            if (beat_idx == frame_beats - 1)
            begin
                void'(exp_trig.pop_front());
                beat_idx = 0;
                frames_seen++;
            end
            else
            begin
                beat_idx++;
            end
        end
    endtask

    // converter stream and tready driven on the falling edge
    always @(negedge AXIS_ACLK)
    begin
        if (stream_on)
        begin
            if (send_trig)
            begin
                next_word = trigger_word();
                if (trig_expect)
                    exp_trig.push_back(word_idx);
                send_trig = 1'b0;
            end
            else
            begin
                next_word = quiet_word();
            end
            word_log[word_idx] = next_word;
            word_idx++;
            s_axis_tvalid = 1'b1;
            s_axis_tdata = next_word;
            rnd = $random(seed);
            m_axis_tready = ready_random ? rnd[0] : 1'b1;
        end
    end

    // output monitor samples the values from before the edge
    always @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            if (reset_edges > 0)
            begin
                assert (m_axis_tvalid === 1'b0)
                    else report_mismatch("m_axis_tvalid", 0, m_axis_tvalid);
                assert (m_axis_tuser === 1'b0)
                    else report_mismatch("m_axis_tuser", 0, m_axis_tuser);
                assert (m_axis_tlast === 1'b0)
                    else report_mismatch("m_axis_tlast", 0, m_axis_tlast);
                assert (capture_full === 1'b0)
                    else report_mismatch("capture_full", 0, capture_full);
            end
            reset_edges++;
            held = 1'b0;
        end
        else
        begin
            assert (m_axis_tvalid || (!m_axis_tuser && !m_axis_tlast))
                else report_failure("tuser or tlast high without tvalid");
            // a stalled beat must not move
            if (held)
            begin
                assert (m_axis_tvalid === 1'b1)
                    else report_failure("tvalid dropped before the beat was taken");
                assert (m_axis_tdata === held_data)
                    else report_mismatch("m_axis_tdata while stalled", held_data, m_axis_tdata);
                assert (m_axis_tuser === held_user)
                    else report_mismatch("m_axis_tuser while stalled", held_user, m_axis_tuser);
                assert (m_axis_tlast === held_last)
                    else report_mismatch("m_axis_tlast while stalled", held_last, m_axis_tlast);
            end
            if (m_axis_tvalid && !m_axis_tready)
                stall_count++;
            if (m_axis_tvalid && m_axis_tready)
            begin
                beats_taken++;
                check_beat();
            end
            held = m_axis_tvalid && !m_axis_tready;
            held_data = m_axis_tdata;
            held_user = m_axis_tuser;
            held_last = m_axis_tlast;
        end
    end

    task request_trigger(logic expect_frame);
        trig_expect = expect_frame;
        send_trig = 1'b1;
        wait (!send_trig);
        @(posedge AXIS_ACLK);
    endtask

    task wait_frames(int target);
        wait (frames_seen >= target);
        @(posedge AXIS_ACLK);
    endtask

    // enough written words after a drain to refill the pre window
    task settle_after_frame(int quiet);
        while (capture_full)
            @(posedge AXIS_ACLK);
        repeat (quiet) @(posedge AXIS_ACLK);
    endtask

    task automatic finish_test(string name, int errs_before);
        if (errors == errs_before)
        begin
            tests_passed++;
            $display("%s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge AXIS_ACLK);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d frames seen", cycle_count, frames_seen);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        seed = 32'h2e46d6a5;
        AXIS_ARESETN = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata = '0;
        m_axis_tready = 1'b1;
        stream_on = 1'b0;
        send_trig = 1'b0;
        trig_expect = 1'b0;
        ready_random = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        word_idx = 0;
        beat_idx = 0;
        beats_taken = 0;
        frames_seen = 0;
        tuser_count = 0;
        tlast_count = 0;
        stall_count = 0;
        reset_edges = 0;
        held = 1'b0;
        mark = errors;
        repeat (3) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        AXIS_ARESETN = 1'b1;
        @(posedge AXIS_ACLK);
        stream_on = 1'b1;

        repeat (40)
        begin
            @(posedge AXIS_ACLK);
            assert (m_axis_tvalid === 1'b0)
                else report_mismatch("m_axis_tvalid", 0, m_axis_tvalid);
            assert (capture_full === 1'b0)
                else report_mismatch("capture_full", 0, capture_full);
        end
        finish_test("reset and quiet stream", mark);

        mark = errors;
        request_trigger(1'b1);
        wait_frames(1);
        finish_test("single frame with tready high", mark);

        mark = errors;
        settle_after_frame(8);
        request_trigger(1'b1);
        wait_frames(2);
        assert (tuser_count == frames_seen && tlast_count == frames_seen)
            else report_failure("tuser or tlast count differs from the frame count");
        finish_test("frame markers", mark);

        mark = errors;
        ready_random = 1'b1;
        settle_after_frame(8);
        request_trigger(1'b1);
        wait_frames(3);
        ready_random = 1'b0;
        assert (stall_count > 0) else report_failure("random tready never stalled the drain");
        finish_test("random back-pressure", mark);

        // trigger level while full must not start a frame
        mark = errors;
        settle_after_frame(8);
        request_trigger(1'b1);
        while (!capture_full)
            @(posedge AXIS_ACLK);
        request_trigger(1'b0);
        wait_frames(4);
        settle_after_frame(8);
        request_trigger(1'b1);
        wait_frames(5);
        settle_after_frame(20);
        assert (beats_taken == frames_seen * frame_beats)
            else report_failure("more beats arrived than the expected frames hold");
        finish_test("retrigger after drain", mark);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- adc_capture.f
source/stream_fmt_pkg.sv
source/capture_cfg_pkg.sv
source/threshold_trigger.sv
source/m_axis_if.sv
source/ring_buffer.sv
source/adc_capture_top.sv
test/tb_adc_capture.sv
